/* src.f */
design/soc_map_pkg.sv
design/soc_timing_pkg.sv
design/reset_hold.sv
design/mmio_decoder.sv
design/time_base.sv
design/countdown_timer.sv
design/mmio_read_mux.sv
design/timer_soc_top.sv
bench/tb_timer_soc.sv

/* Makefile */
# Verilator build and run for the timer block

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_timer_soc
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := >>> FAIL

SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

test: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q '$(FAIL_MSG)' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_timer_soc.sv */
`timescale 1ns/100ps

module tb_timer_soc
    import soc_map_pkg::*;
    import soc_timing_pkg::*;
();

    localparam int NUM_T      = 4;
    localparam int TICK_DIV   = 5;       // Short ticks keep the run brief
    localparam int CLK_PERIOD = 20;
    localparam int SEED       = 73381;
    localparam int MAX_ROWS   = 64;
    localparam int PPS_PULSES = 3;

    // Row operations
    localparam int OP_WRITE     = 0;
    localparam int OP_READ      = 1;   // Exact compare
    localparam int OP_READ_LE   = 2;   // Read no more than expected
    localparam int OP_READ_WAIT = 3;   // Poll a slot, data column is the timeout
    localparam int OP_IRQ_WAIT  = 4;   // Poll o_irq, data column is the timeout
    localparam int OP_IRQ_CHECK = 5;
    localparam int OP_PULSE_PPS = 6;   // Data column is the pulse count

    logic                  clk;
    logic                  i_ext_rst_n;
    logic [ADDR_W-1:0]     i_addr;
    logic                  i_wr;
    logic [DATA_W-1:0]     i_wdata;
    logic                  i_pps;
    logic [DATA_W-1:0]     o_rdata;
    logic [NUM_T-1:0]      o_irq;

    // Stimulus table, one test per row
    string             row_name [MAX_ROWS];
    int                row_op   [MAX_ROWS];
    logic [ADDR_W-1:0] row_addr [MAX_ROWS];
    logic [DATA_W-1:0] row_data [MAX_ROWS];
    logic [DATA_W-1:0] row_exp  [MAX_ROWS];
    int                n_rows;
    int                n_pass;
    int                n_fail;

    timer_soc_top #(.NUM_TIMERS(NUM_T), .TICK_DIV(TICK_DIV)) u_dut (
        .clk         (clk),
        .i_ext_rst_n (i_ext_rst_n),
        .i_addr      (i_addr),
        .i_wr        (i_wr),
        .i_wdata     (i_wdata),
        .i_pps       (i_pps),
        .o_rdata     (o_rdata),
        .o_irq       (o_irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==============================
    // Address and data helpers
    // ==============================
    function automatic logic [ADDR_W-1:0] slot_addr(input int slot);
        return {PERI_PAGE, slot[SLOT_W-1:0], 2'b00};   // Word aligned, peripheral page
    endfunction

    function automatic logic [DATA_W-1:0] sysinfo_word(input int pps);
        return {pps[PPS_W-1:0], CHIP_ID, VERSION};
    endfunction

    task automatic add_row(input string name, input int op, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] data, input logic [DATA_W-1:0] exp);
        row_name[n_rows] = name;
        row_op[n_rows]   = op;
        row_addr[n_rows] = addr;
        row_data[n_rows] = data;
        row_exp[n_rows]  = exp;
        n_rows++;
    endtask

    // ==============================
    // Bus and pin drivers
    // ==============================
    task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        @(posedge clk);
        i_addr  <= addr;
        i_wdata <= data;
        i_wr    <= 1'b1;
        @(posedge clk);                 // DUT takes the strobe on this edge
        i_wr    <= 1'b0;
    endtask

    task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        @(posedge clk);
        i_addr <= addr;
        @(negedge clk);                 // Read data settled mid cycle
        data = o_rdata;
    endtask

    task automatic poll_read(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp,
                             input int limit, output bit hit, output logic [DATA_W-1:0] got);
        int n;
        n   = 0;
        hit = 1'b0;
        got = '0;
        @(posedge clk);
        i_addr <= addr;
        while (!hit && n < limit) begin
            @(negedge clk);
            got = o_rdata;
            hit = (got == exp);
            n++;
        end
    endtask

    task automatic poll_irq(input logic [NUM_T-1:0] exp, input int limit,
                            output bit hit, output logic [NUM_T-1:0] got);
        int n;
        n   = 0;
        hit = 1'b0;
        got = '0;
        while (!hit && n < limit) begin
            @(negedge clk);
            got = o_irq;
            hit = (got == exp);
            n++;
        end
    endtask

    task automatic pulse_pps(input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            i_pps <= 1'b1;
            repeat (4) @(posedge clk);  // High 4 cycles
            i_pps <= 1'b0;
            repeat (4) @(posedge clk);  // Low 4 cycles, count settles meanwhile
        end
    endtask

    // ==============================
    // Table
    // ==============================
    task automatic build_table();
        int unsigned v2;
        v2 = 3 + ($urandom % 18);       // Load value 3 .. 20
        n_rows = 0;
        for (int t = 0; t < NUM_T; t++) begin
            add_row($sformatf("reset_t%0d", t), OP_READ, slot_addr(t), '0, '0);
        end
        add_row("reset_irq",      OP_IRQ_CHECK, '0, '0, '0);
        add_row("reset_sysinfo",  OP_READ, slot_addr(SLOT_SYSINFO), '0, sysinfo_word(0));
        // Timer 2 runs out
        add_row("t2_load",        OP_WRITE, slot_addr(2), DATA_W'(v2), '0);
        add_row("t2_running",     OP_READ_LE, slot_addr(2), '0, DATA_W'(v2));
        add_row("t2_zero",        OP_READ_WAIT, slot_addr(2), DATA_W'(v2 * TICK_DIV + 10), '0);
        add_row("t2_irq_only",    OP_IRQ_WAIT, '0, DATA_W'(v2 * TICK_DIV + 10), 32'h4);
        // Reload clears, zero load stays quiet
        add_row("t2_reload",      OP_WRITE, slot_addr(2), 32'h0010_0000, '0);
        add_row("t2_irq_clear",   OP_IRQ_CHECK, '0, '0, '0);
        add_row("t1_preload",     OP_WRITE, slot_addr(1), 32'h0000_1000, '0);
        add_row("t1_load_zero",   OP_WRITE, slot_addr(1), '0, '0);
        add_row("t1_reads_zero",  OP_READ, slot_addr(1), '0, '0);
        // PPS count
        add_row("pps_pulses",     OP_PULSE_PPS, '0, DATA_W'(PPS_PULSES), '0);
        add_row("pps_count",      OP_READ, slot_addr(SLOT_SYSINFO), '0, sysinfo_word(PPS_PULSES));
        add_row("t1_still_quiet", OP_IRQ_CHECK, '0, '0, '0);
        // Unmapped reads, write without the key
        add_row("sysinfo_nokey",  OP_WRITE, slot_addr(SLOT_SYSINFO), 32'h0000_005A, '0);
        add_row("off_page",       OP_READ, 28'h000_003C, '0, UNMAPPED_READ);
        add_row("slot9",          OP_READ, slot_addr(9), '0, UNMAPPED_READ);
        add_row("nokey_kept",     OP_READ, slot_addr(SLOT_SYSINFO), '0, sysinfo_word(PPS_PULSES));
        // Soft reset with state to clear
        add_row("t0_short",       OP_WRITE, slot_addr(0), 32'd2, '0);
        add_row("t0_irq",         OP_IRQ_WAIT, '0, DATA_W'(2 * TICK_DIV + 10), 32'h1);
        add_row("t1_load",        OP_WRITE, slot_addr(1), 32'h0000_1000, '0);
        add_row("t3_load",        OP_WRITE, slot_addr(3), 32'h0000_1000, '0);
        add_row("soft_reset",     OP_WRITE, slot_addr(SLOT_SYSINFO), 32'h0000_00A5, '0);
        add_row("rst_irq_clear",  OP_IRQ_WAIT, '0, DATA_W'(RESET_HOLD + 10), '0);
        add_row("rst_t3_zero",    OP_READ_WAIT, slot_addr(3), DATA_W'(RESET_HOLD + 10), '0);
        for (int t = 0; t < NUM_T - 1; t++) begin
            add_row($sformatf("rst_t%0d", t), OP_READ, slot_addr(t), '0, '0);
        end
        add_row("rst_sysinfo",    OP_READ, slot_addr(SLOT_SYSINFO), '0, sysinfo_word(0));
    endtask

    // ==============================
    // Row execution
    // ==============================
    task automatic run_row(input int r, output bit ok);
        logic [DATA_W-1:0] got;
        logic [NUM_T-1:0]  irq_got;
        bit                hit;
        ok = 1'b1;
        case (row_op[r])
            OP_WRITE: bus_write(row_addr[r], row_data[r]);
            OP_READ: begin
                bus_read(row_addr[r], got);
                assert (got == row_exp[r]) else begin
                    $display("mismatch %s: expected 0x%08h, actual 0x%08h",
                             row_name[r], row_exp[r], got);
                    ok = 1'b0;
                end
            end
            OP_READ_LE: begin
                bus_read(row_addr[r], got);
                assert (got <= row_exp[r]) else begin
                    $display("mismatch %s: expected at most 0x%08h, actual 0x%08h",
                             row_name[r], row_exp[r], got);
                    ok = 1'b0;
                end
            end
            OP_READ_WAIT: begin
                poll_read(row_addr[r], row_exp[r], int'(row_data[r]), hit, got);
                assert (hit) else begin
                    $display("%s: address 0x%07h never read 0x%08h within %0d cycles, last 0x%08h",
                             row_name[r], row_addr[r], row_exp[r], row_data[r], got);
                    ok = 1'b0;
                end
            end
            OP_IRQ_WAIT: begin
                poll_irq(row_exp[r][NUM_T-1:0], int'(row_data[r]), hit, irq_got);
                assert (hit) else begin
                    $display("%s: o_irq never reached %b within %0d cycles, last %b",
                             row_name[r], row_exp[r][NUM_T-1:0], row_data[r], irq_got);
                    ok = 1'b0;
                end
            end
            OP_IRQ_CHECK: begin
                @(negedge clk);
                irq_got = o_irq;
                assert (irq_got == row_exp[r][NUM_T-1:0]) else begin
                    $display("mismatch %s: expected %b, actual %b",
                             row_name[r], row_exp[r][NUM_T-1:0], irq_got);
                    ok = 1'b0;
                end
            end
            OP_PULSE_PPS: pulse_pps(int'(row_data[r]));
            default: begin
                $display("%s: unknown table operation %0d", row_name[r], row_op[r]);
                ok = 1'b0;
            end
        endcase
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        bit ok;
        i_ext_rst_n <= 1'b0;
        i_addr      <= '0;
        i_wr        <= 1'b0;
        i_wdata     <= '0;
        i_pps       <= 1'b0;
        n_pass = 0;
        n_fail = 0;
        void'($urandom(SEED));          // One seed for the whole run
        build_table();
        repeat (8) @(posedge clk);
        i_ext_rst_n <= 1'b1;
        @(posedge clk);                 // Internal reset flop releases here
        for (int r = 0; r < n_rows; r++) begin
            run_row(r, ok);
            if (ok) begin
                n_pass++;
                $display("test %s ok", row_name[r]);
            end else begin
                n_fail++;
                $display("test %s FAILED", row_name[r]);
            end
        end
        $display("tests: %0d run, %0d passed, %0d failed", n_rows, n_pass, n_fail);
        if (n_fail == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* design/timer_soc_top.sv */
`timescale 1ns/100ps

module timer_soc_top
    import soc_map_pkg::*;
    import soc_timing_pkg::*;
#(
    parameter int NUM_TIMERS = 4,    // 1 .. MAX_TIMERS
    parameter int TICK_DIV   = 25    // 25 MHz clock gives 1 us ticks
) (
    input  logic                  clk,
    input  logic                  i_ext_rst_n,
    input  logic [ADDR_W-1:0]     i_addr,
    input  logic                  i_wr,
    input  logic [DATA_W-1:0]     i_wdata,
    input  logic                  i_pps,
    output logic [DATA_W-1:0]     o_rdata,
    output logic [NUM_TIMERS-1:0] o_irq
);

    logic                               rst_reg_n;
    logic [NUM_TIMERS-1:0]              timer_wr;
    logic                               soft_reset;
    logic [SLOT_W-1:0]                  rd_slot;
    logic                               rd_valid;
    logic                               tick_1us;
    logic [PPS_W-1:0]                   pps_count;
    logic [NUM_TIMERS-1:0][TIMER_W-1:0] counts;

    // Timers must fit below the SYS_INFO slot
    if (NUM_TIMERS < 1 || NUM_TIMERS > MAX_TIMERS) begin : g_bad_num_timers
        $error("NUM_TIMERS %0d outside 1..%0d", NUM_TIMERS, MAX_TIMERS);
    end

    // ==============================
    // Reset and decode
    // ==============================
    reset_hold u_reset_hold (
        .clk          (clk),
        .i_ext_rst_n  (i_ext_rst_n),
        .i_soft_reset (soft_reset),
        .rst_reg_n    (rst_reg_n)
    );

    mmio_decoder #(.NUM_TIMERS(NUM_TIMERS)) u_decoder (
        .clk          (clk),
        .rst_reg_n    (rst_reg_n),
        .i_addr       (i_addr),
        .i_wr         (i_wr),
        .i_wdata_key  (i_wdata[7:0]),
        .o_timer_wr   (timer_wr),
        .o_soft_reset (soft_reset),
        .o_rd_slot    (rd_slot),
        .o_rd_valid   (rd_valid)
    );

    time_base #(.TICK_DIV(TICK_DIV)) u_time_base (
        .clk         (clk),
        .rst_reg_n   (rst_reg_n),
        .i_pps       (i_pps),
        .o_tick_1us  (tick_1us),
        .o_pps_count (pps_count)
    );

    // ==============================
    // Timer bank
    // ==============================
    for (genvar g = 0; g < NUM_TIMERS; g++) begin : g_timer
        countdown_timer u_timer (
            .clk       (clk),
            .rst_reg_n (rst_reg_n),
            .i_wr      (timer_wr[g]),
            .i_wdata   (i_wdata[TIMER_W-1:0]),   // Full word is the count
            .i_tick    (tick_1us),
            .o_count   (counts[g]),
            .o_irq     (o_irq[g])
        );
    end

    mmio_read_mux #(.NUM_TIMERS(NUM_TIMERS)) u_read_mux (
        .i_rd_slot   (rd_slot),
        .i_rd_valid  (rd_valid),
        .i_counts    (counts),
        .i_pps_count (pps_count),
        .o_rdata     (o_rdata)
    );

endmodule

/* design/mmio_read_mux.sv */
`timescale 1ns/100ps

module mmio_read_mux
    import soc_map_pkg::*;
    import soc_timing_pkg::*;
#(
    parameter int NUM_TIMERS = 4
) (
    input  logic [SLOT_W-1:0]                  i_rd_slot,
    input  logic                               i_rd_valid,    // Address in peripheral page
    input  logic [NUM_TIMERS-1:0][TIMER_W-1:0] i_counts,      // Live count of every timer
    input  logic [PPS_W-1:0]                   i_pps_count,
    output logic [DATA_W-1:0]                  o_rdata        // Same-cycle read data
);

    logic [DATA_W-1:0] sysinfo_word;

    // PPS count high, then chip ID, version in the low byte
    assign sysinfo_word = DATA_W'({i_pps_count, CHIP_ID, VERSION});

    // ==============================
    // Read select
    // ==============================
    always_comb begin
        o_rdata = UNMAPPED_READ;                        // Outside page or empty slot
        if (i_rd_valid) begin
            if (i_rd_slot == SLOT_SYSINFO) begin
                o_rdata = sysinfo_word;
            end else begin
                for (int i = 0; i < NUM_TIMERS; i++) begin
                    if (i_rd_slot == SLOT_W'(i)) begin
                        o_rdata = DATA_W'(i_counts[i]);
                    end
                end
            end
        end
    end

endmodule

/* design/countdown_timer.sv */
`timescale 1ns/100ps

module countdown_timer import soc_timing_pkg::*; (
    input  logic               clk,
    input  logic               rst_reg_n,
    input  logic               i_wr,       // Load strobe for this channel
    input  logic [TIMER_W-1:0] i_wdata,    // New count in ticks
    input  logic               i_tick,     // Microsecond tick
    output logic [TIMER_W-1:0] o_count,
    output logic               o_irq       // Level, held until the next load
);

    logic expire;   // Last tick of a running count

    assign expire = i_tick && (o_count == TIMER_W'(1));

    // ==============================
    // Count and interrupt
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            o_count <= '0;
            o_irq   <= 1'b0;
        end else if (i_wr) begin
            // Load wins over a tick in the same cycle
            o_count <= i_wdata;
            o_irq   <= 1'b0;                 // Zero load stays idle, no irq
        end else if (i_tick && (o_count != '0)) begin
            o_count <= o_count - 1'b1;
            if (expire) begin
                o_irq <= 1'b1;               // 1 -> 0 step only
            end
        end
    end

    // Interrupt only appears together with an empty counter
    a_irq_on_zero: assert property (
        @(posedge clk) disable iff (!rst_reg_n)
        $rose(o_irq) |-> (o_count == '0)
    ) else $error("timer irq rose with count %0d", o_count);

endmodule

/* design/time_base.sv */
`timescale 1ns/100ps

module time_base import soc_timing_pkg::*; #(
    parameter int TICK_DIV = 25   // Clock cycles per microsecond
) (
    input  logic             clk,
    input  logic             rst_reg_n,
    input  logic             i_pps,         // Asynchronous pulse per second
    output logic             o_tick_1us,    // One cycle in every TICK_DIV
    output logic [PPS_W-1:0] o_pps_count
);

    localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic [1:0]       pps_sync;     // Two-flop synchronizer
    logic             pps_prev;     // Last synchronized level
    logic             pps_rise;

    // ==============================
    // Microsecond divider
    // ==============================
    assign o_tick_1us = (div_cnt == DIV_W'(TICK_DIV - 1));   // Last count before wrap

    always_ff @(posedge clk) begin
        if (!rst_reg_n || o_tick_1us) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ==============================
    // PPS capture
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            pps_sync <= '0;
            pps_prev <= 1'b0;
        end else begin
            pps_sync <= {pps_sync[0], i_pps};
            pps_prev <= pps_sync[1];
        end
    end

    assign pps_rise = pps_sync[1] && !pps_prev;   // Edge reaches the count 3 cycles after pin

    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            o_pps_count <= '0;
        end else if (pps_rise) begin
            o_pps_count <= o_pps_count + 1'b1;     // Free wrap at 2^PPS_W
        end
    end

endmodule

/* design/mmio_decoder.sv */
`timescale 1ns/100ps

module mmio_decoder import soc_map_pkg::*; #(
    parameter int NUM_TIMERS = 4
) (
    input  logic                  clk,            // Assertion clock only
    input  logic                  rst_reg_n,      // Assertion disable only
    input  logic [ADDR_W-1:0]     i_addr,
    input  logic                  i_wr,           // One-cycle write strobe
    input  logic [7:0]            i_wdata_key,    // Low byte of the write data
    output logic [NUM_TIMERS-1:0] o_timer_wr,     // Load strobe per timer
    output logic                  o_soft_reset,   // Key written to SYS_INFO
    output logic [SLOT_W-1:0]     o_rd_slot,
    output logic                  o_rd_valid      // Address is in the peripheral page
);

    bus_addr_u addr_u;
    logic      page_hit;   // Page matches and access is word aligned
    logic      wr_hit;     // Write into the peripheral page

    assign addr_u.raw = i_addr;

    // ==============================
    // Page match
    // ==============================
    assign page_hit = (addr_u.f.page == PERI_PAGE) && (addr_u.f.byte_ofs == '0);
    assign wr_hit   = page_hit && i_wr;

    // ==============================
    // Write strobes
    // ==============================
    // Timer i sits at slot i
    always_comb begin
        o_timer_wr = '0;
        for (int i = 0; i < NUM_TIMERS; i++) begin
            if (wr_hit && (addr_u.f.slot == SLOT_W'(i))) begin
                o_timer_wr[i] = 1'b1;
            end
        end
    end

    // Any other byte in SYS_INFO is a silent write
    assign o_soft_reset = wr_hit
                          && (addr_u.f.slot == SLOT_SYSINFO)
                          && (i_wdata_key == SOFT_RESET_KEY);

    // ==============================
    // Read side
    // ==============================
    assign o_rd_valid = page_hit;          // Slot range is checked in the read mux
    assign o_rd_slot  = addr_u.f.slot;

    // A single write can only land in one slot
    a_one_target: assert property (
        @(posedge clk) disable iff (!rst_reg_n)
        $onehot0({o_timer_wr, o_soft_reset})
    ) else $error("decoder raised more than one write target");

endmodule

/* design/reset_hold.sv */
`timescale 1ns/100ps

module reset_hold import soc_timing_pkg::*; (
    input  logic clk,
    input  logic i_ext_rst_n,    // Board reset, already synchronous to clk
    input  logic i_soft_reset,   // One-cycle pulse from the decoder
    output logic rst_reg_n       // Internal reset for the whole block
);

    localparam int HOLD_W = $clog2(RESET_HOLD + 1);   // 6 bits for a hold of 32

    logic [HOLD_W-1:0] hold_cnt;   // Nonzero while the soft reset is held

    // ==============================
    // Hold counter
    // ==============================
    always_ff @(posedge clk) begin
        if (!i_ext_rst_n) begin
            hold_cnt <= '0;                             // Board reset cancels any hold
        end else if (i_soft_reset) begin
            hold_cnt <= HOLD_W'(RESET_HOLD);            // Restart hold, even if running
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    // ==============================
    // Registered reset
    // ==============================
    // One flop after the counter, so the reset falls one edge
    // after the load and stays low RESET_HOLD cycles
    always_ff @(posedge clk) begin
        rst_reg_n <= i_ext_rst_n && (hold_cnt == '0);
    end

    // Counter only ever loads RESET_HOLD and counts down from there
    a_hold_bound: assert property (
        @(posedge clk) disable iff (!i_ext_rst_n)
        hold_cnt <= HOLD_W'(RESET_HOLD)
    ) else $error("reset hold counter above RESET_HOLD: %0d", hold_cnt);

endmodule

/* design/soc_timing_pkg.sv */
package soc_timing_pkg;

    // ==============================
    // Counter widths
    // ==============================
    localparam int TIMER_W = 32;   // Countdown value, in microseconds
    localparam int PPS_W   = 16;   // PPS edges since reset, wraps

    // ==============================
    // Reset stretch
    // ==============================
    // Cycles the internal reset stays low after a soft reset;
    // long enough to let every block settle at its reset value
    localparam int RESET_HOLD = 32;

endpackage

/* design/soc_map_pkg.sv */
package soc_map_pkg;

    // ==============================
    // Bus geometry
    // ==============================
    localparam int ADDR_W = 28;                   // Bus address width
    localparam int DATA_W = 32;                   // Bus data width
    localparam int PAGE_W = 21;                   // Page field, addr[27:7]
    localparam int SLOT_W = 5;                    // Slot field, addr[6:2]
    localparam int BYTE_W = 2;                    // Byte field, addr[1:0]

    localparam logic [PAGE_W-1:0] PERI_PAGE = 21'h10_0000;  // Peripheral page at 0x800_0000

    // ==============================
    // Slot map
    // ==============================
    // Timers take slots 0 .. NUM_TIMERS-1
    localparam int                MAX_TIMERS   = 15;
    localparam logic [SLOT_W-1:0] SLOT_SYSINFO = 5'd15;  // Chip info, soft reset on write

    localparam logic [7:0] SOFT_RESET_KEY = 8'hA5;       // Low byte of a SYS_INFO write
    localparam logic [7:0] CHIP_ID        = 8'h01;
    localparam logic [7:0] VERSION        = 8'h10;       // Major in high nibble

    localparam logic [DATA_W-1:0] UNMAPPED_READ = '1;    // Open bus reads as ones

    // Address word, whole or split into page, slot and byte offset
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [PAGE_W-1:0] page;
            logic [SLOT_W-1:0] slot;
            logic [BYTE_W-1:0] byte_ofs;   // Must be zero, word access only
        } f;
    } bus_addr_u;

endpackage
